// File: Makefile
SIM := obj_dir/VpermAccelTb

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  test   build with Verilator, run the testbench, check sim.log"
	@echo "  clean  remove obj_dir and sim.log"
	@echo "  help   show this list"

$(SIM): compile.f $(wildcard hw/*.sv verif/*.sv)
	verilator --binary --timing --assert -Wno-fatal --top-module permAccelTb -f compile.f

test: $(SIM)
	./$(SIM) +verilator+error+limit+1000 > sim.log 2>&1; rc=$$?; cat sim.log; \
	if grep -q "CHECKS FAILED" sim.log; then echo "test failed"; exit 1; fi; \
	exit $$rc

clean:
	rm -rf obj_dir sim.log

// File: compile.f
hw/permPkg.sv
hw/resetNormalizer.sv
hw/syncFifo.sv
hw/topManager.sv
hw/permutationPipeline.sv
hw/multiPermutationPipeline.sv
hw/permutationAccelerator.sv
verif/permAccel_properties.sv
verif/permAccelTb.sv

// File: hw/multiPermutationPipeline.sv
`timescale 1ns/100ps

module multiPermutationPipeline #(
    parameter int PIPE_STAGES       = permPkg::PIPE_STAGES,
    parameter int ORIGIN_DEPTH_LOG2 = permPkg::ORIGIN_DEPTH_LOG2,
    parameter int RESULT_DEPTH_LOG2 = permPkg::RESULT_DEPTH_LOG2
) (
    input  logic                 clk,
    input  logic                 rst,

    input  logic                 writeTop,
    input  logic                 writeBot,
    input  permPkg::funcWord_t   funcIn,
    output logic                 readyForInput,

    input  logic                 iready,
    output logic                 ovalid,
    output permPkg::resultWord_t resultOut
);

    import permPkg::*;

    funcWord_t   currentTop;
    logic        stallInput;
    logic        originEmpty;
    logic        originFull;
    logic        originOut;
    origin_t     headOrigin;
    origin_t     originIn;
    logic        pipelineReady;
    logic        botAvailable;
    pipeResult_t botResult;
    logic        grabbing;
    logic [39:0] clockCounter;
    logic [39:0] heldCount;
    logic        holdStamp;
    resultWord_t stampWord;
    resultWord_t pipeWord;

    topManager topMngr (
        .clk             (clk),
        .rst             (rst),
        .topIn           (funcIn),
        .topInValid      (writeTop),
        .pipelineIsEmpty (originEmpty),
        .topOut          (currentTop),
        .stallInput      (stallInput)
    );

    assign originIn = writeTop ? ORIGIN_TOP : ORIGIN_BOT;

    // one entry per accepted word keeps results in input order
    syncFifo #(
        .WIDTH      (1),
        .DEPTH_LOG2 (ORIGIN_DEPTH_LOG2)
    ) originQueue (
        .clk         (clk),
        .rst         (rst),
        .writeEnable (writeTop || writeBot),
        .dataIn      (originIn),
        .full        (originFull),
        .readEnable  (grabbing),
        .dataOut     (originOut),
        .empty       (originEmpty)
    );

    assign headOrigin = origin_t'(originOut);

    permutationPipeline #(
        .PIPE_STAGES       (PIPE_STAGES),
        .RESULT_DEPTH_LOG2 (RESULT_DEPTH_LOG2)
    ) permPipe (
        .clk              (clk),
        .rst              (rst),
        .top              (currentTop),
        .bot              (funcIn),
        .writeBot         (writeBot),
        .readyForInputBot (pipelineReady),
        .grabResult       (grabbing && headOrigin == ORIGIN_BOT),
        .resultsAvailable (botAvailable),
        .result           (botResult)
    );

    assign readyForInput = pipelineReady && !stallInput && !originFull;

    always_ff @(posedge clk) begin
        if (rst)
            clockCounter <= '0;
        else
            clockCounter <= clockCounter + 1'b1;
    end

    // a timestamp waiting for iready stays frozen until taken
    always_ff @(posedge clk) begin
        if (rst)
            holdStamp <= 1'b0;
        else
            holdStamp <= ovalid && !iready && headOrigin == ORIGIN_TOP;
        if (!holdStamp)
            heldCount <= clockCounter;
    end

    always_comb begin
        stampWord.stamp.zeros      = '0;
        stampWord.stamp.clockCount = holdStamp ? heldCount : clockCounter;
        pipeWord.pipe              = botResult;
    end

    // timestamp is always ready but a bot result only once buffered
    assign ovalid    = !originEmpty && (headOrigin == ORIGIN_TOP || botAvailable);
    assign resultOut = (headOrigin == ORIGIN_TOP) ? stampWord : pipeWord;
    assign grabbing  = ovalid && iready;

endmodule

// File: hw/permPkg.sv
package permPkg;

    // one boolean function for tops and bots alike
    typedef struct packed {
        logic [63:0] upper;
        logic [63:0] lower;
    } funcWord_t;

    // pipeline result word
    typedef struct packed {
        logic        eccStatus;   // reserved, reads 0
        logic [1:0]  reserved;
        logic [12:0] pcoeffCount;
        logic [47:0] pcoeffSum;
    } pipeResult_t;

    // timestamp result word
    typedef struct packed {
        logic [23:0] zeros;
        logic [39:0] clockCount;
    } stampResult_t;

    // the output word, decoded by where it came from
    typedef union packed {
        pipeResult_t  pipe;
        stampResult_t stamp;
    } resultWord_t;

    // origin of a queued result
    typedef enum logic {
        ORIGIN_TOP = 1'b0,   // timestamp source
        ORIGIN_BOT = 1'b1    // permutation pipeline
    } origin_t;

    // defaults for the top level parameters
    parameter int PIPE_STAGES       = 4;
    parameter int INIT_CYCLES       = 16;
    parameter int ORIGIN_DEPTH_LOG2 = 5;
    parameter int RESULT_DEPTH_LOG2 = 4;

endpackage

// File: hw/permutationAccelerator.sv
`timescale 1ns/100ps

module permutationAccelerator #(
    parameter int PIPE_STAGES       = permPkg::PIPE_STAGES,
    parameter int INIT_CYCLES       = permPkg::INIT_CYCLES,
    parameter int ORIGIN_DEPTH_LOG2 = permPkg::ORIGIN_DEPTH_LOG2,
    parameter int RESULT_DEPTH_LOG2 = permPkg::RESULT_DEPTH_LOG2
) (
    input  logic                 clk,
    input  logic                 resetn,

    input  logic                 ivalid,
    input  logic                 startNewTop,   // dataIn is a top, not a bot
    input  permPkg::funcWord_t   dataIn,
    output logic                 oready,

    input  logic                 iready,
    output logic                 ovalid,
    output permPkg::resultWord_t resultOut
);

    import permPkg::*;

    funcWord_t stagedWord;
    logic      botValid;
    logic      topValid;
    logic      rst;
    logic      isInitialized;
    logic      pipelineReady;

    // one-deep stage so a word can be taken before init completes
    always_ff @(posedge clk) begin
        if (oready)
            stagedWord <= dataIn;
    end

    always_ff @(posedge clk) begin
        if (!resetn) begin
            botValid <= 1'b0;
            topValid <= 1'b0;
        end else if (oready) begin
            botValid <= ivalid && !startNewTop;
            topValid <= ivalid && startNewTop;
        end
    end

    resetNormalizer #(
        .INIT_CYCLES (INIT_CYCLES)
    ) rstNormalizer (
        .clk           (clk),
        .resetn        (resetn),
        .rst           (rst),
        .isInitialized (isInitialized)
    );

    // stage drains into the pipeline on the same edge it refills
    assign oready = (pipelineReady && isInitialized) || (!botValid && !topValid && !rst);

    multiPermutationPipeline #(
        .PIPE_STAGES       (PIPE_STAGES),
        .ORIGIN_DEPTH_LOG2 (ORIGIN_DEPTH_LOG2),
        .RESULT_DEPTH_LOG2 (RESULT_DEPTH_LOG2)
    ) multiPermPipe (
        .clk           (clk),
        .rst           (rst),
        .writeTop      (topValid && oready),
        .writeBot      (botValid && oready),
        .funcIn        (stagedWord),
        .readyForInput (pipelineReady),
        .iready        (iready),
        .ovalid        (ovalid),
        .resultOut     (resultOut)
    );

endmodule

// File: hw/permutationPipeline.sv
`timescale 1ns/100ps

module permutationPipeline #(
    parameter int PIPE_STAGES       = 4,   // needs at least 3
    parameter int RESULT_DEPTH_LOG2 = 4
) (
    input  logic                 clk,
    input  logic                 rst,

    input  permPkg::funcWord_t   top,
    input  permPkg::funcWord_t   bot,
    input  logic                 writeBot,
    output logic                 readyForInputBot,

    input  logic                 grabResult,
    output logic                 resultsAvailable,
    output permPkg::pipeResult_t result
);

    import permPkg::*;

    localparam int NSLICES = 4;   // 32-bit slices of the 128-bit word
    localparam logic [RESULT_DEPTH_LOG2:0] CREDIT_MAX = {1'b1, {RESULT_DEPTH_LOG2{1'b0}}};

    typedef struct packed {
        logic                    covered;
        logic [NSLICES-1:0][5:0] slices;
    } partial_t;

    function automatic logic [5:0] popCount32(input logic [31:0] v);
        logic [5:0] n;
        n = '0;
        for (int i = 0; i < 32; i++)
            n = n + 6'(v[i]);
        return n;
    endfunction

    logic [PIPE_STAGES:1]     stageValid;
    funcWord_t                s1Bot;
    logic                     s1Covered;
    partial_t                 partialStage [2:PIPE_STAGES-1];
    pipeResult_t              resultReg;
    logic [7:0]               bitTotal;
    logic [RESULT_DEPTH_LOG2:0] creditCount;   // bots in flight plus buffered
    logic                     grabDone;
    logic                     resultsEmpty;

    always_ff @(posedge clk) begin
        if (rst)
            stageValid <= '0;
        else
            stageValid <= {stageValid[PIPE_STAGES-1:1], writeBot};
    end

    // stage 1 cover test with no bot bit outside the top
    always_ff @(posedge clk) begin
        s1Bot     <= bot;
        s1Covered <= ((bot & ~top) == '0);
    end

    // stage 2 counts ones per slice
    always_ff @(posedge clk) begin
        partialStage[2].covered <= s1Covered;
        for (int s = 0; s < NSLICES; s++)
            partialStage[2].slices[s] <= popCount32(s1Bot[s*32 +: 32]);
    end

    // plain delay stages when PIPE_STAGES exceeds 3
    for (genvar k = 3; k < PIPE_STAGES; k++) begin : gDelay
        always_ff @(posedge clk)
            partialStage[k] <= partialStage[k-1];
    end

    always_comb begin
        bitTotal = '0;
        for (int s = 0; s < NSLICES; s++)
            bitTotal = bitTotal + 8'(partialStage[PIPE_STAGES-1].slices[s]);
    end

    // last stage sums the slices and formats the result
    always_ff @(posedge clk) begin
        resultReg.eccStatus   <= 1'b0;
        resultReg.reserved    <= 2'b00;
        resultReg.pcoeffCount <= 13'(partialStage[PIPE_STAGES-1].covered);
        resultReg.pcoeffSum   <= partialStage[PIPE_STAGES-1].covered ? 48'(bitTotal) : '0;
    end

    syncFifo #(
        .WIDTH      ($bits(pipeResult_t)),
        .DEPTH_LOG2 (RESULT_DEPTH_LOG2)
    ) resultBuffer (
        .clk         (clk),
        .rst         (rst),
        .writeEnable (stageValid[PIPE_STAGES]),
        .dataIn      (resultReg),
        .full        (),   // credits keep it from filling past depth
        .readEnable  (grabResult),
        .dataOut     (result),
        .empty       (resultsEmpty)
    );

    assign resultsAvailable = !resultsEmpty;
    assign grabDone         = grabResult && resultsAvailable;

    always_ff @(posedge clk) begin
        if (rst) begin
            creditCount <= '0;
        end else begin
            case ({writeBot, grabDone})
                2'b10:   creditCount <= creditCount + 1'b1;
                2'b01:   creditCount <= creditCount - 1'b1;
                default: creditCount <= creditCount;
            endcase
        end
    end

    assign readyForInputBot = (creditCount < CREDIT_MAX);

endmodule

// File: hw/resetNormalizer.sv
`timescale 1ns/100ps

module resetNormalizer #(
    parameter int INIT_CYCLES = 16
) (
    input  logic clk,
    input  logic resetn,
    output logic rst,
    output logic isInitialized
);

    localparam int CNT_W = $clog2(INIT_CYCLES + 1);

    logic [2:0]       rstStretch;
    logic [CNT_W-1:0] initCount;

    // rst follows resetn plus two extra cycles
    always_ff @(posedge clk) begin
        if (!resetn) begin
            rstStretch <= 3'b111;
        end else begin
            rstStretch <= {rstStretch[1:0], 1'b0};
        end
    end

    assign rst = rstStretch[2];

    // give the pipeline time to settle before claiming ready
    always_ff @(posedge clk) begin
        if (rst) begin
            initCount     <= '0;
            isInitialized <= 1'b0;
        end else if (!isInitialized) begin
            if (initCount == CNT_W'(INIT_CYCLES - 1))
                isInitialized <= 1'b1;
            initCount <= initCount + 1'b1;
        end
    end

endmodule

// File: hw/syncFifo.sv
`timescale 1ns/100ps

module syncFifo #(
    parameter int WIDTH      = 8,
    parameter int DEPTH_LOG2 = 4
) (
    input  logic             clk,
    input  logic             rst,

    input  logic             writeEnable,
    input  logic [WIDTH-1:0] dataIn,
    output logic             full,

    input  logic             readEnable,
    output logic [WIDTH-1:0] dataOut,
    output logic             empty
);

    localparam int DEPTH = 1 << DEPTH_LOG2;

    logic [WIDTH-1:0]    mem [DEPTH];
    logic [DEPTH_LOG2:0] wrPtr;   // extra msb tells full from empty
    logic [DEPTH_LOG2:0] rdPtr;
    logic                doWrite;
    logic                doRead;

    assign doWrite = writeEnable && !full;
    assign doRead  = readEnable && !empty;

    always_ff @(posedge clk) begin
        if (doWrite)
            mem[wrPtr[DEPTH_LOG2-1:0]] <= dataIn;
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            wrPtr <= '0;
            rdPtr <= '0;
        end else begin
            if (doWrite)
                wrPtr <= wrPtr + 1'b1;
            if (doRead)
                rdPtr <= rdPtr + 1'b1;
        end
    end

    assign empty = (wrPtr == rdPtr);
    assign full  = (wrPtr[DEPTH_LOG2] != rdPtr[DEPTH_LOG2]) &&
                   (wrPtr[DEPTH_LOG2-1:0] == rdPtr[DEPTH_LOG2-1:0]);

    // show-ahead so the head word is always on the output
    assign dataOut = mem[rdPtr[DEPTH_LOG2-1:0]];

endmodule

// File: hw/topManager.sv
`timescale 1ns/100ps

module topManager (
    input  logic               clk,
    input  logic               rst,

    input  permPkg::funcWord_t topIn,
    input  logic               topInValid,
    input  logic               pipelineIsEmpty,

    output permPkg::funcWord_t topOut,
    output logic               stallInput
);

    import permPkg::*;

    funcWord_t pendingTop;
    logic      pendingValid;

    always_ff @(posedge clk) begin
        if (topInValid)
            pendingTop <= topIn;
    end

    // a new top waits until no older result is outstanding
    always_ff @(posedge clk) begin
        if (rst) begin
            pendingValid <= 1'b0;
            topOut       <= '0;   // all zeros until the first top
        end else begin
            if (topInValid) begin
                pendingValid <= 1'b1;
            end else if (pendingValid && pipelineIsEmpty) begin
                topOut       <= pendingTop;
                pendingValid <= 1'b0;
            end
        end
    end

    // no new words while a change is pending
    assign stallInput = pendingValid;

endmodule

// File: verif/permAccelTb.sv
`timescale 1ns/100ps

module permAccelTb;

    import permPkg::*;

    localparam int MIXED_WORDS  = 300;
    // twice the reset, init, directed and worst-case mixed test lengths
    localparam int CYCLE_LIMIT  = 2 * (4 + INIT_CYCLES + 800 + MIXED_WORDS * 30);
    localparam int READY_HIGH   = 0;
    localparam int READY_LOW    = 1;
    localparam int READY_RANDOM = 2;

    typedef struct packed {
        origin_t     origin;
        resultWord_t word;
    } expected_t;

    logic        clk = 1'b0;
    logic        resetn;
    logic        ivalid;
    logic        startNewTop;
    funcWord_t   dataIn;
    logic        oready;
    logic        iready;
    logic        ovalid;
    resultWord_t resultOut;

    expected_t   expQueue[$];   // one entry per accepted word in input order
    funcWord_t   modelTop;      // top the DUT applies to the next accepted bot
    funcWord_t   lastSentTop;
    logic [39:0] lastStamp;
    int          lastStampCycle;
    logic [31:0] rngState;
    logic        lastOready;
    int          readyMode;
    int          checkCount;
    int          errorCount;
    int          cycleCount;
    string       testName;

    permutationAccelerator #(
        .PIPE_STAGES       (PIPE_STAGES),
        .INIT_CYCLES       (INIT_CYCLES),
        .ORIGIN_DEPTH_LOG2 (ORIGIN_DEPTH_LOG2),
        .RESULT_DEPTH_LOG2 (RESULT_DEPTH_LOG2)
    ) dut (
        .clk         (clk),
        .resetn      (resetn),
        .ivalid      (ivalid),
        .startNewTop (startNewTop),
        .dataIn      (dataIn),
        .oready      (oready),
        .iready      (iready),
        .ovalid      (ovalid),
        .resultOut   (resultOut)
    );

    always #5 clk = ~clk;

    always @(posedge clk) begin
        cycleCount <= cycleCount + 1;
        if (cycleCount >= CYCLE_LIMIT) begin
            $display("timeout after %0d cycles, %0d results outstanding", cycleCount,
                     expQueue.size());
            $display("CHECKS FAILED");
            $finish;
        end
    end

    function automatic logic [31:0] xorshift(input logic [31:0] s);
        logic [31:0] x;
        x = s ^ (s << 13);
        x = x ^ (x >> 17);
        x = x ^ (x << 5);
        return x;
    endfunction

    function automatic logic [31:0] nextRandom();
        rngState = xorshift(rngState);
        return rngState;
    endfunction

    function automatic funcWord_t randomWord();
        funcWord_t w;
        w.upper = {nextRandom(), nextRandom()};
        w.lower = {nextRandom(), nextRandom()};
        return w;
    endfunction

    // about half of these fall inside the last top sent
    function automatic funcWord_t randomBot();
        funcWord_t   w;
        logic [31:0] r;
        w = randomWord();
        r = nextRandom();
        if (r[0])
            w = w & lastSentTop;
        return w;
    endfunction

    function automatic int countOnes(input logic [127:0] v);
        int n;
        n = 0;
        while (v != '0) begin
            v = v & (v - 1'b1);   // drop lowest set bit
            n++;
        end
        return n;
    endfunction

    function automatic void checkValue(input logic [63:0] expected, input logic [63:0] actual);
        checkCount++;
        assert (actual === expected) else begin
            errorCount++;
            $display("FAILED %s: expected %h, actual %h", testName, expected, actual);
        end
    endfunction

    task automatic recordInput();
        expected_t e;
        logic      covered;
        e = '0;
        if (startNewTop) begin
            e.origin = ORIGIN_TOP;
            modelTop = dataIn;
        end else begin
            covered                 = ((dataIn | modelTop) == modelTop);
            e.origin                = ORIGIN_BOT;
            e.word.pipe.pcoeffCount = 13'(covered);
            e.word.pipe.pcoeffSum   = covered ? 48'(countOnes(dataIn)) : 48'd0;
        end
        expQueue.push_back(e);
    endtask

    task automatic checkOutput();
        expected_t e;
        checkCount++;
        assert (expQueue.size() > 0) else begin
            errorCount++;
            $display("%s: a result came out with no word outstanding", testName);
        end
        if (expQueue.size() > 0) begin
            e = expQueue.pop_front();
            if (e.origin == ORIGIN_TOP) begin
                checkValue(64'(0), 64'(resultOut.stamp.zeros));
                checkCount++;
                assert (resultOut.stamp.clockCount > lastStamp) else begin
                    errorCount++;
                    $display("FAILED %s: expected clockCount above %0d, actual %0d",
                             testName, lastStamp, resultOut.stamp.clockCount);
                end
                lastStamp      = resultOut.stamp.clockCount;
                lastStampCycle = cycleCount;
            end else begin
                checkValue(e.word, resultOut);
            end
        end
    endtask

    task automatic driveIready();
        logic [31:0] r;
        r = nextRandom();
        case (readyMode)
            READY_LOW:    iready = 1'b0;
            READY_RANDOM: iready = (r[1:0] != 2'b00);
            default:      iready = 1'b1;
        endcase
    endtask

    task automatic setReadyMode(input int mode);
        readyMode = mode;
        driveIready();
    endtask

    // starts on a falling edge with inputs driven and returns on the next one
    task automatic clockStep(output logic accepted);
        #4;   // just ahead of the rising edge
        lastOready = oready;
        accepted   = ivalid && oready;
        if (ovalid && iready)
            checkOutput();
        if (accepted)
            recordInput();
        @(negedge clk);
        driveIready();
    endtask

    task automatic sendWord(input logic isTop, input funcWord_t word);
        logic accepted;
        ivalid      = 1'b1;
        startNewTop = isTop;
        dataIn      = word;
        if (isTop)
            lastSentTop = word;
        accepted = 1'b0;
        while (!accepted)
            clockStep(accepted);
        ivalid = 1'b0;
    endtask

    task automatic drainResults();
        logic accepted;
        setReadyMode(READY_HIGH);
        while (expQueue.size() > 0)
            clockStep(accepted);
        repeat (PIPE_STAGES + 4)
            clockStep(accepted);   // nothing more may come out
    endtask

    task automatic resetTest();
        logic accepted;
        int   waitCount;
        testName = "reset";
        resetn   = 1'b0;
        repeat (4) begin
            @(negedge clk);
            checkCount++;
            assert (ovalid === 1'b0 && oready === 1'b0) else begin
                errorCount++;
                $display("%s: ovalid or oready high during reset", testName);
            end
        end
        resetn    = 1'b1;
        waitCount = 0;
        while (!lastOready && waitCount < 4 * INIT_CYCLES) begin
            clockStep(accepted);
            waitCount++;
        end
        checkCount++;
        assert (lastOready) else begin
            errorCount++;
            $display("%s: oready never rose after reset", testName);
        end
        setReadyMode(READY_HIGH);
    endtask

    task automatic coverTest();
        funcWord_t top;
        testName = "cover rule";
        sendWord(1'b0, '0);   // top is still all zeros here
        sendWord(1'b0, randomWord());
        top = randomWord();
        sendWord(1'b1, top);
        sendWord(1'b0, top);
        sendWord(1'b0, '0);
        sendWord(1'b0, ~top);
        for (int i = 0; i < 12; i++)
            sendWord(1'b0, randomBot());
        drainResults();
    endtask

    // the counter advances once per clock between the two reads
    task automatic stampTest();
        logic [39:0] firstStamp;
        int          firstCycle;
        testName = "timestamps";
        sendWord(1'b1, randomWord());
        drainResults();
        firstStamp = lastStamp;
        firstCycle = lastStampCycle;
        sendWord(1'b1, randomWord());
        drainResults();
        checkValue(64'(firstStamp) + 64'(lastStampCycle - firstCycle), 64'(lastStamp));
    endtask

    task automatic topChangeTest();
        funcWord_t lowTop;
        funcWord_t highTop;
        testName = "top change";
        lowTop   = {64'h0, 64'hFFFF_FFFF_FFFF_FFFF};
        highTop  = {64'hFFFF_FFFF_FFFF_FFFF, 64'h0};
        sendWord(1'b1, lowTop);
        sendWord(1'b0, {64'h0, 64'h00FF});
        sendWord(1'b0, {64'hF0, 64'h0});
        sendWord(1'b0, {64'h0, 64'h00FF});
        sendWord(1'b1, highTop);   // older bots still in flight
        sendWord(1'b0, {64'h0, 64'h00FF});
        sendWord(1'b0, {64'hF0, 64'h0});
        drainResults();
    endtask

    task automatic backPressureTest();
        logic accepted;
        int   steps;
        testName    = "back-pressure";
        setReadyMode(READY_LOW);
        ivalid      = 1'b1;
        startNewTop = 1'b0;
        dataIn      = randomBot();
        steps       = 0;
        lastOready  = 1'b1;
        while (lastOready && steps < 64) begin
            clockStep(accepted);
            if (accepted)
                dataIn = randomBot();
            steps++;
        end
        checkCount++;
        assert (!lastOready) else begin
            errorCount++;
            $display("%s: oready stayed high with iready held low", testName);
        end
        setReadyMode(READY_HIGH);
        accepted = 1'b0;
        while (!accepted)
            clockStep(accepted);
        ivalid = 1'b0;
        drainResults();
    endtask

    task automatic mixedTest();
        logic        accepted;
        logic [31:0] r;
        testName = "mixed random";
        setReadyMode(READY_RANDOM);
        for (int i = 0; i < MIXED_WORDS; i++) begin
            r = nextRandom();
            repeat (r[1:0])
                clockStep(accepted);   // idle gap
            if (r[4:2] == 3'b000)
                sendWord(1'b1, randomWord());
            else
                sendWord(1'b0, randomBot());
        end
        drainResults();
    endtask

    initial begin
        resetn         = 1'b0;
        ivalid         = 1'b0;
        startNewTop    = 1'b0;
        dataIn         = '0;
        iready         = 1'b0;
        readyMode      = READY_LOW;
        rngState       = 32'h9c06;
        modelTop       = '0;
        lastSentTop    = '0;
        lastStamp      = '0;
        lastStampCycle = 0;
        lastOready     = 1'b0;
        checkCount     = 0;
        errorCount     = 0;
        cycleCount     = 0;
        resetTest();
        coverTest();
        stampTest();
        topChangeTest();
        backPressureTest();
        mixedTest();
        $display("checks: %0d, check errors: %0d, assertion errors: %0d",
                 checkCount, errorCount, dut.props.failCount);
        if (errorCount == 0 && dut.props.failCount == 0)
            $display("ALL CHECKS PASSED");
        else
            $display("CHECKS FAILED");
        $finish;
    end

endmodule

// File: verif/permAccel_properties.sv
`timescale 1ns/100ps

module permAccelProperties (
    input logic                 clk,
    input logic                 rst,
    input logic                 oready,
    input logic                 ovalid,
    input logic                 iready,
    input permPkg::resultWord_t resultOut,
    input permPkg::origin_t     headOrigin
);

    import permPkg::*;

    int failCount = 0;

    // stretched reset keeps both handshakes quiet
    resetQuiet: assert property (@(posedge clk) rst |-> !ovalid && !oready)
        else begin
            failCount++;
            $error("ovalid or oready high while rst is high");
        end

    holdValid: assert property (@(posedge clk) disable iff (rst)
        ovalid && !iready |=> ovalid)
        else begin
            failCount++;
            $error("ovalid dropped before the result was taken");
        end

    // a waiting result must not move until taken
    holdResult: assert property (@(posedge clk) disable iff (rst)
        ovalid && !iready |=> $stable(resultOut))
        else begin
            failCount++;
            $error("resultOut changed while waiting for iready");
        end

    stampUpperZero: assert property (@(posedge clk) disable iff (rst)
        ovalid && headOrigin == ORIGIN_TOP |-> resultOut.stamp.zeros == '0)
        else begin
            failCount++;
            $error("timestamp result has nonzero upper bits");
        end

endmodule

bind permutationAccelerator permAccelProperties props (
    .clk        (clk),
    .rst        (rst),
    .oready     (oready),
    .ovalid     (ovalid),
    .iready     (iready),
    .resultOut  (resultOut),
    .headOrigin (multiPermPipe.headOrigin)
);
